/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := touch_i2c_tb
FILELIST := touch_i2c.f
OBJ_DIR  := obj_dir
RUN_ARGS := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/i2c_byte_engine.sv */
// I2C bit engine on open-drain SCL and SDA
// Quarter-period divider, start, stop, byte write and byte read with stretching
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       cmd_valid,
    input  i2c_cmd_t   cmd,
    output logic       cmd_ready,
    output logic       rsp_valid,
    output i2c_rsp_t   rsp,
    input  logic       scl_in,     // Resolved bus levels
    input  logic       sda_in,
    output logic       scl_oe,     // 1 pulls the line low
    output logic       sda_oe,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    input  logic       byte_ready
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [2:0] {
        E_IDLE,
        E_START, // Also used for the repeated start
        E_STOP,
        E_BIT,   // Eight data bits, MSB first
        E_HOLD,  // Read byte waits for the packer, SCL low
        E_ACK    // Ninth bit
    } eng_state_e;

    eng_state_e    state;
    logic [QW-1:0] qcnt;    // Clocks within a quarter
    logic [1:0]    q;       // Quarter within a bit time
    logic [2:0]    bit_cnt;
    logic [7:0]    shreg;   // Out on the MSB, in on the LSB
    i2c_cmd_t      cmd_q;
    logic          ack_r;
    logic          running;
    logic          stall;
    logic          tick;
    logic          is_read;
    logic          scl_d;
    logic          sda_d;

    assign running = (state == E_START) || (state == E_STOP) ||
                     (state == E_BIT) || (state == E_ACK);
    assign stall   = !scl_oe && !scl_in;  // Target still holds SCL low
    assign tick    = running && !stall && (qcnt == QW'(CLK_DIV - 1));
    assign is_read = (cmd_q.op == OP_READ);

    assign cmd_ready  = (state == E_IDLE);
    assign byte_valid = (state == E_HOLD);
    assign byte_data  = shreg;
    assign rsp        = '{rdata: shreg, ack: ack_r};

    // Line levels per quarter; anything not listed keeps its level
    always_comb begin
        scl_d = scl_oe;
        sda_d = sda_oe;
        case (state)
            E_START: begin
                case (q)
                    2'd0: sda_d = 1'b0; // Release SDA while SCL low or idle
                    2'd1: scl_d = 1'b0;
                    2'd2: sda_d = 1'b1; // Falling SDA with SCL high
                    default: scl_d = 1'b1;
                endcase
            end
            E_STOP: begin
                case (q)
                    2'd0: sda_d = 1'b1; // SDA low before SCL rises
                    2'd1: scl_d = 1'b0;
                    2'd2: sda_d = 1'b0; // Rising SDA with SCL high
                    default: ;
                endcase
            end
            E_BIT, E_ACK: begin
                case (q)
                    2'd0: begin
                        if (state == E_BIT) begin
                            sda_d = !is_read && !shreg[7];
                        end else begin
                            sda_d = is_read && !cmd_q.last; // Our ACK, NACK on last
                        end
                    end
                    2'd1: scl_d = 1'b0;
                    2'd3: scl_d = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= E_IDLE;
            qcnt      <= '0;
            q         <= 2'd0;
            bit_cnt   <= 3'd0;
            rsp_valid <= 1'b0;
            scl_oe    <= 1'b0;
            sda_oe    <= 1'b0;
        end else begin
            scl_oe    <= scl_d;
            sda_oe    <= sda_d;
            rsp_valid <= 1'b0;
            if (!running) begin
                qcnt <= '0;
            end else if (!stall) begin
                qcnt <= (qcnt == QW'(CLK_DIV - 1)) ? '0 : qcnt + 1'b1;
            end
            if (tick) begin
                q <= q + 2'd1;
            end
            case (state)
                E_IDLE: begin
                    if (cmd_valid) begin
                        q       <= 2'd0;
                        bit_cnt <= 3'd0;
                        case (cmd.op)
                            OP_START, OP_RESTART: state <= E_START;
                            OP_STOP:              state <= E_STOP;
                            default:              state <= E_BIT;
                        endcase
                    end
                end
                E_START, E_STOP, E_ACK: begin
                    if (tick && q == 2'd3) begin
                        state     <= E_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                E_BIT: begin
                    if (tick && q == 2'd3) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= is_read ? E_HOLD : E_ACK;
                        end
                    end
                end
                E_HOLD: if (byte_ready) state <= E_ACK; // Bus paused until taken
                default: state <= E_IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (state == E_IDLE && cmd_valid) begin
            cmd_q <= cmd;
            shreg <= cmd.wdata;
        end else if (tick && q == 2'd1) begin // SCL has risen
            if (state == E_BIT) begin
                shreg <= {shreg[6:0], sda_in};
            end
            if (state == E_ACK) begin
                ack_r <= !sda_in;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/i2c_pkg.sv */
// I2C bus-level types shared by the read sequencer and the byte engine
// Command opcodes, command and response structs for one command in flight
`default_nettype none

package i2c_pkg;

    // Byte engine opcodes
    typedef enum logic [2:0] {
        OP_START,   // Start condition from an idle bus
        OP_RESTART, // Repeated start with SCL held low
        OP_WRITE,   // Eight data bits plus target ACK
        OP_READ,    // Eight data bits plus our ACK or NACK
        OP_STOP     // Stop condition, bus released
    } i2c_op_e;

    // Command from the sequencer to the byte engine, 12 bits
    typedef struct packed {
        i2c_op_e    op;
        logic [7:0] wdata; // Byte to send on OP_WRITE
        logic       last;  // NACK after this read
    } i2c_cmd_t;

    // Response back to the sequencer, 9 bits
    typedef struct packed {
        logic [7:0] rdata; // Byte seen on the bus
        logic       ack;   // Target pulled SDA low on the ninth bit
    } i2c_rsp_t;

endpackage

`default_nettype wire

/* rtl/touch_coord_packer.sv */
// Collects the four register bytes and decodes them into one touch point
// Point is held on a valid/ready output until taken
`timescale 1ns/1ps
`default_nettype none

module touch_coord_packer
    import touch_pkg::*;
(
    input  logic         clk,
    input  logic         nRst,
    input  logic         byte_valid,
    input  logic [7:0]   byte_data,
    output logic         byte_ready,
    output logic         point_valid,
    output touch_point_t point,
    input  logic         point_ready
);

    localparam int IW = $clog2(TOUCH_BYTES);

    logic [7:0]    byte_buf [TOUCH_BYTES-1]; // Registers 0x03 to 0x05
    logic [IW-1:0] byte_idx;
    logic          last_byte;
    logic          take;

    assign last_byte  = (byte_idx == IW'(TOUCH_BYTES - 1));
    // Only a fourth byte has to wait for the previous point
    assign byte_ready = !(last_byte && point_valid && !point_ready);
    assign take       = byte_valid && byte_ready;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            byte_idx    <= '0;
            point_valid <= 1'b0;
        end else begin
            if (point_valid && point_ready) begin
                point_valid <= 1'b0;
            end
            if (take) begin
                byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
                if (last_byte) begin
                    point_valid <= 1'b1; // Wins over the handshake clear
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (last_byte) begin
                point.event_flag <= byte_buf[0][7:6];
                point.touch_id   <= byte_buf[2][7:4];
                point.x          <= {byte_buf[0][3:0], byte_buf[1]};
                point.y          <= {byte_buf[2][3:0], byte_data};
            end else begin
                byte_buf[byte_idx] <= byte_data;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/touch_i2c_top.sv */
// Touchscreen coordinate reader top level
// Interrupt detect, burst read sequencer, I2C byte engine and point packer
`timescale 1ns/1ps
`default_nettype none

module touch_i2c_top
    import touch_pkg::*;
    import i2c_pkg::*;
#(
    parameter int         CLK_DIV  = 4,     // System clocks per quarter SCL period
    parameter logic [6:0] DEV_ADDR = 7'h38  // Panel address
) (
    input  logic         clk,
    input  logic         nRst,
    input  logic         irq,
    input  logic         scl_in,
    input  logic         sda_in,
    output logic         scl_oe,
    output logic         sda_oe,
    output logic         point_valid,
    output touch_point_t point,
    input  logic         point_ready,
    output logic         bus_error
);

    logic       req_valid;
    logic       req_ready;
    logic       cmd_valid;
    logic       cmd_ready;
    i2c_cmd_t   cmd;
    logic       rsp_valid;
    i2c_rsp_t   rsp;
    logic       byte_valid;
    logic       byte_ready;
    logic [7:0] byte_data;

    touch_irq_detect i_touch_irq_detect (
        .clk       (clk),
        .nRst      (nRst),
        .irq       (irq),
        .req_ready (req_ready),
        .req_valid (req_valid)
    );

    touch_read_sequencer #(
        .DEV_ADDR (DEV_ADDR)
    ) i_touch_read_sequencer (
        .clk       (clk),
        .nRst      (nRst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .bus_error (bus_error)
    );

    i2c_byte_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_i2c_byte_engine (
        .clk        (clk),
        .nRst       (nRst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_ready (byte_ready)
    );

    touch_coord_packer i_touch_coord_packer (
        .clk         (clk),
        .nRst        (nRst),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_ready  (byte_ready),
        .point_valid (point_valid),
        .point       (point),
        .point_ready (point_ready)
    );

endmodule

`default_nettype wire

/* rtl/touch_irq_detect.sv */
// Panel interrupt front end
// Synchronizes irq, finds its rising edge and keeps one pending read request
`timescale 1ns/1ps
`default_nettype none

module touch_irq_detect (
    input  logic clk,
    input  logic nRst,
    input  logic irq,       // Asynchronous, active high
    input  logic req_ready, // Sequencer is idle
    output logic req_valid
);

    logic [1:0] irq_sync; // Two-flop synchronizer
    logic       irq_prev; // Last synchronized level
    logic       rise;
    logic       pending;

    assign rise      = irq_sync[1] && !irq_prev;
    assign req_valid = pending;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            irq_sync <= 2'b00;
            irq_prev <= 1'b0;
            pending  <= 1'b0;
        end else begin
            irq_sync <= {irq_sync[0], irq};
            irq_prev <= irq_sync[1];
            // New edge wins over the handshake, so edges merge
            pending  <= rise || (pending && !(req_valid && req_ready));
        end
    end

endmodule

`default_nettype wire

/* rtl/touch_pkg.sv */
// Touchscreen types: register map, sequencer states and the decoded point
`default_nettype none

package touch_pkg;

    // Register map of the panel
    localparam logic [7:0] TOUCH_REG_BASE = 8'h03; // First register of the burst
    localparam int         TOUCH_BYTES    = 4;     // Registers 0x03 to 0x06

    // Read sequencer states, one command per state
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_ADDR_W,  // Address with write bit
        S_REG,     // Register pointer
        S_RESTART,
        S_ADDR_R,  // Address with read bit
        S_READ,    // Four data bytes
        S_STOP,
        S_ABORT    // Stop after an address NACK
    } seq_state_e;

    // One decoded touch point, 30 bits
    typedef struct packed {
        logic [1:0]  event_flag; // Reg 0x03 bits 7:6
        logic [3:0]  touch_id;   // Reg 0x05 bits 7:4
        logic [11:0] x;          // Reg 0x03 bits 3:0 over reg 0x04
        logic [11:0] y;          // Reg 0x05 bits 3:0 over reg 0x06
    } touch_point_t;

endpackage

`default_nettype wire

/* rtl/touch_read_sequencer.sv */
// Burst read sequencer for the touch panel
// Issues start, address+W, pointer, restart, address+R, four reads and stop
`timescale 1ns/1ps
`default_nettype none

module touch_read_sequencer
    import touch_pkg::*;
    import i2c_pkg::*;
#(
    parameter logic [6:0] DEV_ADDR = 7'h38
) (
    input  logic     clk,
    input  logic     nRst,
    input  logic     req_valid,
    output logic     req_ready,
    output logic     cmd_valid,
    output i2c_cmd_t cmd,
    input  logic     cmd_ready,
    input  logic     rsp_valid,
    input  i2c_rsp_t rsp,
    output logic     bus_error
);

    seq_state_e state;
    logic [1:0] rd_cnt;   // Read byte number within the burst
    logic       cmd_sent; // Command accepted, waiting for its response
    logic       last_rd;

    assign last_rd   = (rd_cnt == 2'(TOUCH_BYTES - 1));
    assign req_ready = (state == S_IDLE);
    assign cmd_valid = (state != S_IDLE) && !cmd_sent;

    // Command for the current state
    always_comb begin
        cmd = '{op: OP_STOP, wdata: 8'h00, last: 1'b0};
        case (state)
            S_START:   cmd.op = OP_START;
            S_ADDR_W: begin
                cmd.op    = OP_WRITE;
                cmd.wdata = {DEV_ADDR, 1'b0};
            end
            S_REG: begin
                cmd.op    = OP_WRITE;
                cmd.wdata = TOUCH_REG_BASE;
            end
            S_RESTART: cmd.op = OP_RESTART;
            S_ADDR_R: begin
                cmd.op    = OP_WRITE;
                cmd.wdata = {DEV_ADDR, 1'b1};
            end
            S_READ: begin
                cmd.op   = OP_READ;
                cmd.last = last_rd; // NACK on the fourth byte
            end
            default:   cmd.op = OP_STOP; // S_STOP and S_ABORT
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= S_IDLE;
            rd_cnt    <= 2'd0;
            cmd_sent  <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            bus_error <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                cmd_sent <= 1'b1;
            end
            if (state == S_IDLE) begin
                rd_cnt <= 2'd0;
                if (req_valid) begin
                    state <= S_START;
                end
            end else if (rsp_valid) begin
                cmd_sent <= 1'b0; // Next state issues a fresh command
                case (state)
                    S_START:   state <= S_ADDR_W;
                    S_ADDR_W:  state <= rsp.ack ? S_REG : S_ABORT;
                    S_REG:     state <= rsp.ack ? S_RESTART : S_ABORT;
                    S_RESTART: state <= S_ADDR_R;
                    S_ADDR_R:  state <= rsp.ack ? S_READ : S_ABORT;
                    S_READ: begin
                        rd_cnt <= rd_cnt + 2'd1;
                        if (last_rd) begin
                            state <= S_STOP;
                        end
                    end
                    S_STOP:    state <= S_IDLE;
                    S_ABORT: begin
                        state     <= S_IDLE;
                        bus_error <= 1'b1; // One-cycle pulse after the stop
                    end
                    default:   state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* test/i2c_target_model.sv */
// Behavioral I2C target for the touch panel
// Serves registers 0x03 to 0x06 in one burst, records the traffic, can stretch SCL
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
    parameter int STRETCH_NS = 1500 // SCL held low this long after each falling edge
) (
    input  logic        scl,         // Resolved bus levels
    input  logic        sda,
    input  logic [6:0]  addr,        // Address this target answers to
    input  logic [31:0] regs,        // Registers 0x03 to 0x06, 0x03 in the top byte
    input  logic        stretch,
    output logic        scl_oe,      // 1 pulls the line low
    output logic        sda_oe,
    output logic [7:0]  seen_addr_w, // First byte after a start
    output logic [7:0]  seen_ptr,    // Register pointer
    output logic [7:0]  seen_addr_r, // Byte after the repeated start
    output logic [3:0]  seen_acks,   // Controller ACKs, first read in the MSB
    output int          stop_cnt
);

    // Start or repeated start: SDA falls while SCL is high
    task automatic wait_start();
        @(negedge sda);
        while (scl !== 1'b1) @(negedge sda);
    endtask

    task automatic recv_byte(output logic [7:0] b);
        repeat (8) begin
            @(posedge scl);
            b = {b[6:0], sda}; // MSB first
        end
    endtask

    task automatic give_ack();
        @(negedge scl);
        sda_oe = 1'b1;
        @(negedge scl);
        sda_oe = 1'b0;
    endtask

    // Starts on the falling SCL edge that ends the previous ninth bit
    task automatic send_byte(input logic [7:0] b, output logic ack);
        int k;
        for (k = 7; k >= 0; k--) begin
            sda_oe = !b[k];
            @(negedge scl);
        end
        sda_oe = 1'b0; // Controller owns the ninth bit
        @(posedge scl);
        ack = !sda;
        @(negedge scl);
    endtask

    initial begin : serve
        logic [7:0] b;
        logic       ack;
        int         i;
        sda_oe      = 1'b0;
        seen_addr_w = 8'h00;
        seen_ptr    = 8'h00;
        seen_addr_r = 8'h00;
        seen_acks   = 4'h0;
        forever begin
            wait_start();
            seen_ptr    = 8'h00;
            seen_addr_r = 8'h00;
            seen_acks   = 4'h0;
            recv_byte(b);
            seen_addr_w = b;
            if (b[7:1] == addr && !b[0]) begin // No ACK otherwise, controller stops
                give_ack();
                recv_byte(b);
                seen_ptr = b;
                give_ack();
                wait_start();
                recv_byte(b);
                seen_addr_r = b;
                if (b[7:1] == addr && b[0]) begin
                    give_ack();
                    for (i = 0; i < 4; i++) begin
                        send_byte(regs[31 - 8*i -: 8], ack);
                        seen_acks = {seen_acks[2:0], ack};
                        if (!ack) break; // NACK ends the burst
                    end
                end
            end
        end
    end

    // Clock stretching after every falling SCL edge
    initial begin
        scl_oe = 1'b0;
        forever begin
            @(negedge scl);
            if (stretch) begin
                scl_oe = 1'b1;
                #(STRETCH_NS);
                scl_oe = 1'b0;
            end
        end
    end

    // Stop: SDA rises while SCL is high
    initial begin
        stop_cnt = 0;
        forever begin
            @(posedge sda);
            if (scl === 1'b1) stop_cnt++;
        end
    end

endmodule

`default_nettype wire

/* test/touch_i2c_checker.sv */
// Protocol assertions for the touch reader, bound to the top level
// Output hold, SDA timing against SCL, error and point exclusive
`timescale 1ns/1ps
`default_nettype none

module touch_i2c_checker
    import touch_pkg::*;
    import i2c_pkg::*;
(
    input logic         clk,
    input logic         nRst,
    input logic         scl_in,      // Resolved SCL
    input logic         sda_oe,
    input logic         point_valid,
    input logic         point_ready,
    input touch_point_t point,
    input logic         bus_error,
    input i2c_cmd_t     eng_cmd      // Command the byte engine is working on
);

    int assert_fails = 0; // Failed assertions so far

    property point_held;
        @(posedge clk) disable iff (!nRst)
        point_valid && !point_ready |=> point_valid && $stable(point);
    endproperty

    // SDA moves under a high SCL only for start and stop conditions
    property sda_while_scl_low;
        @(posedge clk) disable iff (!nRst)
        (sda_oe != $past(sda_oe)) && scl_in |-> eng_cmd.op inside {OP_START, OP_RESTART, OP_STOP};
    endproperty

    property error_or_point;
        @(posedge clk) disable iff (!nRst)
        !(bus_error && point_valid);
    endproperty

    a_point_held: assert property (point_held) else begin
        assert_fails++;
        $error("point or point_valid changed while point_ready was low");
    end

    a_sda_timing: assert property (sda_while_scl_low) else begin
        assert_fails++;
        $error("sda_oe changed while SCL was high outside start or stop");
    end

    a_error_excl: assert property (error_or_point) else begin
        assert_fails++;
        $error("bus_error and point_valid high in the same cycle");
    end

endmodule

bind touch_i2c_top touch_i2c_checker i_checker (
    .clk         (clk),
    .nRst        (nRst),
    .scl_in      (scl_in),
    .sda_oe      (sda_oe),
    .point_valid (point_valid),
    .point_ready (point_ready),
    .point       (point),
    .bus_error   (bus_error),
    .eng_cmd     (i_i2c_byte_engine.cmd_q)
);

`default_nettype wire

/* test/touch_i2c_tb.sv */
// Testbench for the touchscreen coordinate reader
// Table of register bytes and bus conditions, one irq-driven burst read per row
`timescale 1ns/1ps
`default_nettype none

module touch_i2c_tb
    import touch_pkg::*;
();

    localparam int         CLK_DIV  = 4;
    localparam logic [6:0] DEV_ADDR = 7'h38;
    localparam int         NUM_ROWS = 10;
    localparam int         WATCHDOG = NUM_ROWS * 13 * 9 * 4 * CLK_DIV * 4; // Cycles

    typedef struct packed {
        logic [31:0] regs;      // Registers 0x03 to 0x06
        logic [6:0]  addr;      // Address the target answers to
        logic        stretch;
        logic [15:0] stall;     // Cycles point_ready stays low after point_valid
        logic        extra_irq; // Two more irq edges during the stall
        logic        use_rand;  // Take regs from the LFSR
    } test_row_t;

    logic         clk;
    logic         nRst;
    logic         irq;
    logic         point_ready;
    logic         point_valid;
    logic         bus_error;
    touch_point_t point;
    logic         dut_scl_oe;
    logic         dut_sda_oe;
    logic         mdl_scl_oe;
    logic         mdl_sda_oe;
    wire          scl;
    wire          sda;
    logic [6:0]   mdl_addr;
    logic [31:0]  mdl_regs;
    logic         mdl_stretch;
    logic [7:0]   seen_addr_w;
    logic [7:0]   seen_ptr;
    logic [7:0]   seen_addr_r;
    logic [3:0]   seen_acks;
    int           stop_cnt;

    test_row_t    rows [NUM_ROWS];
    touch_point_t got_points [$]; // Points taken by the handshake
    int           err_pulses = 0;
    int           err_cnt    = 0;
    int           fail_tests = 0;
    logic [31:0]  lfsr;

    // Open drain with pullup
    assign scl = !(dut_scl_oe || mdl_scl_oe);
    assign sda = !(dut_sda_oe || mdl_sda_oe);

    touch_i2c_top #(
        .CLK_DIV  (CLK_DIV),
        .DEV_ADDR (DEV_ADDR)
    ) i_touch_i2c_top (
        .clk         (clk),
        .nRst        (nRst),
        .irq         (irq),
        .scl_in      (scl),
        .sda_in      (sda),
        .scl_oe      (dut_scl_oe),
        .sda_oe      (dut_sda_oe),
        .point_valid (point_valid),
        .point       (point),
        .point_ready (point_ready),
        .bus_error   (bus_error)
    );

    i2c_target_model i_target (
        .scl         (scl),
        .sda         (sda),
        .addr        (mdl_addr),
        .regs        (mdl_regs),
        .stretch     (mdl_stretch),
        .scl_oe      (mdl_scl_oe),
        .sda_oe      (mdl_sda_oe),
        .seen_addr_w (seen_addr_w),
        .seen_ptr    (seen_ptr),
        .seen_addr_r (seen_addr_r),
        .seen_acks   (seen_acks),
        .stop_cnt    (stop_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Handshakes and error pulses, seen before the edge updates the DUT
    always @(posedge clk) begin
        if (point_valid && point_ready) got_points.push_back(point);
        if (bus_error) err_pulses++;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG);
        $display("Result: FAILED");
        $finish;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        int         i;
        for (i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]}; // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        return b;
    endfunction

    // Register bytes to touch point
    function automatic touch_point_t expected_point(input logic [31:0] regs);
        touch_point_t p;
        p.event_flag = regs[31:30];                // 0x03 bits 7:6
        p.touch_id   = regs[15:12];                // 0x05 bits 7:4
        p.x          = {regs[27:24], regs[23:16]}; // 0x03 low nibble over 0x04
        p.y          = {regs[11:8], regs[7:0]};    // 0x05 low nibble over 0x06
        return p;
    endfunction

    task automatic check_point(input string name, input touch_point_t got,
                               input touch_point_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_irq();
        irq = 1'b1;
        wait_cycles(4);
        irq = 1'b0;
        wait_cycles(4);
    endtask

    task automatic load_table();
        // regs, address, stretch, stall, extra irq, random bytes
        rows[0] = '{32'h4A5C_312E, 7'h38, 1'b0, 16'd0,    1'b0, 1'b0};
        rows[1] = '{32'hC000_F000, 7'h38, 1'b1, 16'd0,    1'b0, 1'b0}; // X and Y zero
        rows[2] = '{32'h8FFF_0FFF, 7'h38, 1'b0, 16'd40,   1'b0, 1'b0}; // X and Y full
        rows[3] = '{32'h1122_3344, 7'h29, 1'b0, 16'd0,    1'b0, 1'b0}; // Wrong address
        rows[4] = '{32'h4567_2ABC, 7'h38, 1'b0, 16'd2500, 1'b1, 1'b0}; // Bus pauses
        rows[5] = '{32'h0,         7'h38, 1'b0, 16'd0,    1'b0, 1'b1};
        rows[6] = '{32'h0,         7'h38, 1'b1, 16'd0,    1'b0, 1'b1};
        rows[7] = '{32'h5566_7788, 7'h39, 1'b1, 16'd0,    1'b0, 1'b0}; // Neighbour address
        rows[8] = '{32'h0,         7'h38, 1'b0, 16'd30,   1'b0, 1'b1};
        rows[9] = '{32'h47FF_3800, 7'h38, 1'b0, 16'd0,    1'b0, 1'b0}; // 0x7FF and 0x800
    endtask

    task automatic run_row(input int idx, input test_row_t row);
        touch_point_t exp_pt;
        logic [31:0]  regs;
        logic         match;
        int           exp_txn;
        int           errs_before;
        int           err_base;
        int           stop_base;
        int           i;
        regs = row.regs;
        if (row.use_rand) begin
            for (i = 0; i < 4; i++) regs = {regs[23:0], rand_byte()};
        end
        match       = (row.addr == DEV_ADDR);
        exp_txn     = (match && row.extra_irq) ? 2 : 1;
        exp_pt      = expected_point(regs);
        errs_before = err_cnt;
        err_base    = err_pulses;
        stop_base   = stop_cnt;
        got_points.delete();
        mdl_addr    = row.addr;
        mdl_regs    = regs;
        mdl_stretch = row.stretch;
        point_ready = (row.stall == 16'd0);
        pulse_irq();
        if (!match) begin
            while (err_pulses == err_base) @(negedge clk);
        end else begin
            if (row.stall != 16'd0) begin
                while (!point_valid) @(negedge clk);
                if (row.extra_irq) begin
                    pulse_irq(); // Both merge into one request
                    pulse_irq();
                end
                wait_cycles(row.stall);
                point_ready = 1'b1;
            end
            while (got_points.size() < exp_txn) @(negedge clk);
        end
        while (stop_cnt < stop_base + exp_txn) @(negedge clk);
        wait_cycles(300); // Nothing more may come out
        check_bit("bus_error", err_pulses != err_base, !match);
        if (got_points.size() != (match ? exp_txn : 0) || err_pulses - err_base > 1) begin
            err_cnt++;
            $display("Test %0d gave %0d points and %0d bus errors, expected %0d and %0d",
                     idx, got_points.size(), err_pulses - err_base,
                     match ? exp_txn : 0, match ? 0 : 1);
        end
        foreach (got_points[i]) check_point("point", got_points[i], exp_pt);
        if (seen_addr_w !== {DEV_ADDR, 1'b0} || (match && (seen_ptr !== TOUCH_REG_BASE ||
            seen_addr_r !== {DEV_ADDR, 1'b1} || seen_acks !== 4'b1110))) begin
            err_cnt++;
            $display("Test %0d bus traffic is not the burst read: %h %h %h, acks %b",
                     idx, seen_addr_w, seen_ptr, seen_addr_r, seen_acks);
        end
        if (err_cnt != errs_before) fail_tests++;
        $display("Test %0d regs %h addr %h stretch %0d stall %0d: %s", idx, regs, row.addr,
                 row.stretch, row.stall, (err_cnt == errs_before) ? "pass" : "fail");
    endtask

    initial begin : main
        int i;
        lfsr        = 32'h82ae;
        nRst        = 1'b0;
        irq         = 1'b0;
        point_ready = 1'b1;
        mdl_addr    = DEV_ADDR;
        mdl_regs    = 32'h0;
        mdl_stretch = 1'b0;
        load_table();
        wait_cycles(4);
        nRst = 1'b1;
        wait_cycles(10);
        for (i = 0; i < NUM_ROWS; i++) run_row(i, rows[i]);
        $display("Tests %0d, failed %0d, errors %0d, assertion failures %0d", NUM_ROWS,
                 fail_tests, err_cnt, i_touch_i2c_top.i_checker.assert_fails);
        if (err_cnt == 0 && i_touch_i2c_top.i_checker.assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* touch_i2c.f */
rtl/i2c_pkg.sv
rtl/touch_pkg.sv
rtl/touch_irq_detect.sv
rtl/touch_read_sequencer.sv
rtl/i2c_byte_engine.sv
rtl/touch_coord_packer.sv
rtl/touch_i2c_top.sv
test/i2c_target_model.sv
test/touch_i2c_checker.sv
test/touch_i2c_tb.sv
